/* hdl/bus_pkg.sv */
/*
 * System bus definitions
 * Widths, response codes and slave indices shared by the interconnect
 * between the core's fetch and memory masters and the AXI4-Lite slaves.
 */
package bus_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [1:0]        resp_t;

	// master that issued the read in flight
	typedef enum logic {
		OWNER_MEM   = 1'b0,
		OWNER_FETCH = 1'b1
	} owner_t;

	// slave map
	localparam int NUM_SLAVES = 2;
	localparam int SLV_EXT    = 0;
	localparam int SLV_TIMER  = 1;

	// AXI response codes, single beat only
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* hdl/slave_link_if.sv */
/*
 * Slave link
 * Request and response channels between the arbiter, one slave port
 * and the response router.
 */
`timescale 1ns/1ps

interface slave_link_if;
	import bus_pkg::*;

	// write request, address and data together
	logic  wr_valid;
	logic  wr_ready;
	addr_t wr_addr;
	data_t wr_data;
	strb_t wr_strb;

	// read request
	logic  rd_valid;
	logic  rd_ready;
	addr_t rd_addr;

	// responses back from the slave
	logic  b_valid;
	logic  b_ready;
	resp_t b_resp;
	logic  r_valid;
	logic  r_ready;
	data_t r_data;
	resp_t r_resp;

	modport arb (output wr_valid, wr_addr, wr_data, wr_strb, rd_valid, rd_addr,
		input wr_ready, rd_ready);

	modport port (input wr_valid, wr_addr, wr_data, wr_strb, rd_valid, rd_addr,
		input b_ready, r_ready,
		output wr_ready, rd_ready, b_valid, b_resp, r_valid, r_data, r_resp);

	modport drain (input b_valid, b_resp, r_valid, r_data, r_resp,
		output b_ready, r_ready);

endinterface

/* hdl/request_arbiter.sv */
/*
 * Request arbiter
 * Decodes master addresses onto slave links, gives the memory master
 * priority on reads and keeps one read and one write in flight.
 */
`timescale 1ns/1ps

module request_arbiter #(
	parameter bus_pkg::addr_t TIMER_BASE = 32'h0200_0000,
	parameter bus_pkg::addr_t TIMER_SPAN = 32'h0001_0000
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_wvalid,
	output logic             mem_wready,
	input  bus_pkg::addr_t   mem_waddr,
	input  bus_pkg::data_t   mem_wdata,
	input  bus_pkg::strb_t   mem_wstrb,
	input  logic             mem_arvalid,
	output logic             mem_arready,
	input  bus_pkg::addr_t   mem_araddr,
	input  logic             fetch_arvalid,
	output logic             fetch_arready,
	input  bus_pkg::addr_t   fetch_araddr,
	input  logic             wr_done,
	input  logic             rd_done,
	output bus_pkg::owner_t  rd_owner,
	slave_link_if.arb        links [bus_pkg::NUM_SLAVES]
);
	import bus_pkg::*;

	logic                  wr_busy, wr_pend, wr_grant, wr_taken;
	logic                  rd_busy, rd_pend, rd_grant, rd_taken;
	logic [NUM_SLAVES-1:0] wr_sel, rd_sel;
	logic [NUM_SLAVES-1:0] wr_ready_v, rd_ready_v, wr_valid_v, rd_valid_v;
	addr_t                 wr_addr_q, rd_addr_q;
	data_t                 wr_data_q;
	strb_t                 wr_strb_q;

	function automatic logic [NUM_SLAVES-1:0] decode(input addr_t addr);
		logic [NUM_SLAVES-1:0] sel;
		sel = '0;
		// unsigned offset compare covers the whole window
		if ((addr - TIMER_BASE) < TIMER_SPAN)
			sel[SLV_TIMER] = 1'b1;
		else
			sel[SLV_EXT] = 1'b1;
		return sel;
	endfunction

	assign mem_wready    = !wr_busy;
	assign mem_arready   = !rd_busy;
	assign fetch_arready = !rd_busy && !mem_arvalid;

	assign wr_grant = mem_wvalid && !wr_busy;
	assign rd_grant = !rd_busy && (mem_arvalid || fetch_arvalid);
	assign wr_taken = wr_pend && |(wr_sel & wr_ready_v);
	assign rd_taken = rd_pend && |(rd_sel & rd_ready_v);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_busy  <= 1'b0;
			wr_pend  <= 1'b0;
			wr_sel   <= '0;
			rd_busy  <= 1'b0;
			rd_pend  <= 1'b0;
			rd_sel   <= '0;
			rd_owner <= OWNER_MEM;
		end else begin
			if (wr_grant) begin
				wr_busy <= 1'b1;
				wr_pend <= 1'b1;
				wr_sel  <= decode(mem_waddr);
			end else begin
				if (wr_taken)
					wr_pend <= 1'b0;
				if (wr_done)
					wr_busy <= 1'b0;
			end
			if (rd_grant) begin
				rd_busy  <= 1'b1;
				rd_pend  <= 1'b1;
				rd_sel   <= decode(mem_arvalid ? mem_araddr : fetch_araddr);
				rd_owner <= mem_arvalid ? OWNER_MEM : OWNER_FETCH;
			end else begin
				if (rd_taken)
					rd_pend <= 1'b0;
				if (rd_done)
					rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_grant) begin
			wr_addr_q <= mem_waddr;
			wr_data_q <= mem_wdata;
			wr_strb_q <= mem_wstrb;
		end
		if (rd_grant)
			rd_addr_q <= mem_arvalid ? mem_araddr : fetch_araddr;
	end

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_link
		assign wr_valid_v[s]     = wr_pend && wr_sel[s];
		assign rd_valid_v[s]     = rd_pend && rd_sel[s];
		assign links[s].wr_valid = wr_valid_v[s];
		assign links[s].wr_addr  = wr_addr_q;
		assign links[s].wr_data  = wr_data_q;
		assign links[s].wr_strb  = wr_strb_q;
		assign links[s].rd_valid = rd_valid_v[s];
		assign links[s].rd_addr  = rd_addr_q;
		assign wr_ready_v[s]     = links[s].wr_ready;
		assign rd_ready_v[s]     = links[s].rd_ready;
	end

	// a second grant waits for the router's done pulse
	a_wr_single: assert property (@(posedge clk) disable iff (!rst_n)
		wr_grant |=> (!wr_grant until wr_done));
	a_rd_single: assert property (@(posedge clk) disable iff (!rst_n)
		rd_grant |=> (!rd_grant until rd_done));
	a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(wr_valid_v) && $onehot0(rd_valid_v));

endmodule

/* hdl/slave_port.sv */
/*
 * Slave port
 * Registers a link request onto the AXI4-Lite channels of one slave,
 * with the slave's base removed, and hands b and r back to the link.
 */
`timescale 1ns/1ps

module slave_port #(
	parameter bus_pkg::addr_t BASE = '0
) (
	input  logic            clk,
	input  logic            rst_n,
	slave_link_if.port      link,
	output logic            awvalid,
	input  logic            awready,
	output bus_pkg::addr_t  awaddr,
	output logic            wvalid,
	input  logic            wready,
	output bus_pkg::data_t  wdata,
	output bus_pkg::strb_t  wstrb,
	input  logic            bvalid,
	output logic            bready,
	input  bus_pkg::resp_t  bresp,
	output logic            arvalid,
	input  logic            arready,
	output bus_pkg::addr_t  araddr,
	input  logic            rvalid,
	output logic            rready,
	input  bus_pkg::data_t  rdata,
	input  bus_pkg::resp_t  rresp
);
	import bus_pkg::*;

	logic aw_pend, w_pend, ar_pend;
	logic wr_take, rd_take;

	// only take a request with the AXI side idle
	assign link.wr_ready = !aw_pend && !w_pend;
	assign link.rd_ready = !ar_pend;
	assign wr_take = link.wr_valid && link.wr_ready;
	assign rd_take = link.rd_valid && link.rd_ready;

	assign awvalid = aw_pend;
	assign wvalid  = w_pend;
	assign arvalid = ar_pend;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
			ar_pend <= 1'b0;
		end else begin
			if (wr_take) begin
				aw_pend <= 1'b1;
				w_pend  <= 1'b1;
			end else begin
				// aw and w may complete in either order
				if (aw_pend && awready)
					aw_pend <= 1'b0;
				if (w_pend && wready)
					w_pend <= 1'b0;
			end
			if (rd_take)
				ar_pend <= 1'b1;
			else if (ar_pend && arready)
				ar_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take) begin
			awaddr <= link.wr_addr - BASE;
			wdata  <= link.wr_data;
			wstrb  <= link.wr_strb;
		end
		if (rd_take)
			araddr <= link.rd_addr - BASE;
	end

	// responses go straight back toward the router
	assign link.b_valid = bvalid;
	assign link.b_resp  = bresp;
	assign bready       = link.b_ready;
	assign link.r_valid = rvalid;
	assign link.r_data  = rdata;
	assign link.r_resp  = rresp;
	assign rready       = link.r_ready;

	a_stable: assert property (@(posedge clk) disable iff (!rst_n)
		((awvalid && !awready) |=> $stable(awaddr)) and
		((wvalid && !wready) |=> $stable({wdata, wstrb})) and
		((arvalid && !arready) |=> $stable(araddr)));

endmodule

/* hdl/response_router.sv */
/*
 * Response router
 * Merges slave responses, sends writes to the memory master and reads
 * to the recorded owner, and signals the arbiter when each completes.
 */
`timescale 1ns/1ps

module response_router (
	slave_link_if.drain     links [bus_pkg::NUM_SLAVES],
	input  bus_pkg::owner_t rd_owner,
	output logic            mem_bvalid,
	input  logic            mem_bready,
	output bus_pkg::resp_t  mem_bresp,
	output logic            mem_rvalid,
	input  logic            mem_rready,
	output bus_pkg::data_t  mem_rdata,
	output bus_pkg::resp_t  mem_rresp,
	output logic            fetch_rvalid,
	input  logic            fetch_rready,
	output bus_pkg::data_t  fetch_rdata,
	output bus_pkg::resp_t  fetch_rresp,
	output logic            wr_done,
	output logic            rd_done
);
	import bus_pkg::*;

	logic [NUM_SLAVES-1:0] b_valid_v, r_valid_v;
	resp_t                 b_resp_v [NUM_SLAVES];
	resp_t                 r_resp_v [NUM_SLAVES];
	data_t                 r_data_v [NUM_SLAVES];
	resp_t                 sel_bresp, sel_rresp;
	data_t                 sel_rdata;
	logic                  any_r, owner_rready;

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_link
		assign b_valid_v[s]     = links[s].b_valid;
		assign b_resp_v[s]      = links[s].b_resp;
		assign r_valid_v[s]     = links[s].r_valid;
		assign r_resp_v[s]      = links[s].r_resp;
		assign r_data_v[s]      = links[s].r_data;
		// ready only to the slave that is answering
		assign links[s].b_ready = mem_bready && b_valid_v[s];
		assign links[s].r_ready = owner_rready && r_valid_v[s];
	end

	always_comb begin
		sel_bresp = RESP_OKAY;
		sel_rresp = RESP_OKAY;
		sel_rdata = '0;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (b_valid_v[s])
				sel_bresp = b_resp_v[s];
			if (r_valid_v[s]) begin
				sel_rresp = r_resp_v[s];
				sel_rdata = r_data_v[s];
			end
		end
	end

	assign mem_bvalid = |b_valid_v;
	assign mem_bresp  = sel_bresp;
	assign wr_done    = mem_bvalid && mem_bready;

	assign any_r        = |r_valid_v;
	assign owner_rready = (rd_owner == OWNER_MEM) ? mem_rready : fetch_rready;
	assign mem_rvalid   = any_r && (rd_owner == OWNER_MEM);
	assign fetch_rvalid = any_r && (rd_owner == OWNER_FETCH);
	assign mem_rdata    = sel_rdata;
	assign mem_rresp    = sel_rresp;
	assign fetch_rdata  = sel_rdata;
	assign fetch_rresp  = sel_rresp;
	assign rd_done      = any_r && owner_rready;

	// one read in flight means one answering slave
	a_one_r: assert final ($onehot0(r_valid_v));

endmodule

/* hdl/bus_interconnect.sv */
/*
 * System bus interconnect
 * Fetch and memory masters onto the external bus and timer slaves.
 */
`timescale 1ns/1ps

module bus_interconnect #(
	parameter bus_pkg::addr_t TIMER_BASE = 32'h0200_0000,
	parameter bus_pkg::addr_t TIMER_SPAN = 32'h0001_0000
) (
	input  logic            clk,
	input  logic            rst_n,
	// memory master
	input  logic            mem_wvalid,
	output logic            mem_wready,
	input  bus_pkg::addr_t  mem_waddr,
	input  bus_pkg::data_t  mem_wdata,
	input  bus_pkg::strb_t  mem_wstrb,
	output logic            mem_bvalid,
	input  logic            mem_bready,
	output bus_pkg::resp_t  mem_bresp,
	input  logic            mem_arvalid,
	output logic            mem_arready,
	input  bus_pkg::addr_t  mem_araddr,
	output logic            mem_rvalid,
	input  logic            mem_rready,
	output bus_pkg::data_t  mem_rdata,
	output bus_pkg::resp_t  mem_rresp,
	// fetch master, reads only
	input  logic            fetch_arvalid,
	output logic            fetch_arready,
	input  bus_pkg::addr_t  fetch_araddr,
	output logic            fetch_rvalid,
	input  logic            fetch_rready,
	output bus_pkg::data_t  fetch_rdata,
	output bus_pkg::resp_t  fetch_rresp,
	// slaves, indexed by SLV_EXT and SLV_TIMER
	output logic            awvalid [bus_pkg::NUM_SLAVES],
	input  logic            awready [bus_pkg::NUM_SLAVES],
	output bus_pkg::addr_t  awaddr  [bus_pkg::NUM_SLAVES],
	output logic            wvalid  [bus_pkg::NUM_SLAVES],
	input  logic            wready  [bus_pkg::NUM_SLAVES],
	output bus_pkg::data_t  wdata   [bus_pkg::NUM_SLAVES],
	output bus_pkg::strb_t  wstrb   [bus_pkg::NUM_SLAVES],
	input  logic            bvalid  [bus_pkg::NUM_SLAVES],
	output logic            bready  [bus_pkg::NUM_SLAVES],
	input  bus_pkg::resp_t  bresp   [bus_pkg::NUM_SLAVES],
	output logic            arvalid [bus_pkg::NUM_SLAVES],
	input  logic            arready [bus_pkg::NUM_SLAVES],
	output bus_pkg::addr_t  araddr  [bus_pkg::NUM_SLAVES],
	input  logic            rvalid  [bus_pkg::NUM_SLAVES],
	output logic            rready  [bus_pkg::NUM_SLAVES],
	input  bus_pkg::data_t  rdata   [bus_pkg::NUM_SLAVES],
	input  bus_pkg::resp_t  rresp   [bus_pkg::NUM_SLAVES]
);
	import bus_pkg::*;

	owner_t rd_owner;
	logic   wr_done, rd_done;

	slave_link_if links [NUM_SLAVES] ();

	request_arbiter #(
		.TIMER_BASE(TIMER_BASE),
		.TIMER_SPAN(TIMER_SPAN)
	) arb0 (
		.clk(clk), .rst_n(rst_n),
		.mem_wvalid(mem_wvalid), .mem_wready(mem_wready),
		.mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
		.mem_arvalid(mem_arvalid), .mem_arready(mem_arready), .mem_araddr(mem_araddr),
		.fetch_arvalid(fetch_arvalid), .fetch_arready(fetch_arready),
		.fetch_araddr(fetch_araddr),
		.wr_done(wr_done), .rd_done(rd_done),
		.rd_owner(rd_owner),
		.links(links)
	);

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
		// timer addresses arrive relative to its base
		slave_port #(
			.BASE((s == SLV_TIMER) ? TIMER_BASE : addr_t'(0))
		) port0 (
			.clk(clk), .rst_n(rst_n),
			.link(links[s]),
			.awvalid(awvalid[s]), .awready(awready[s]), .awaddr(awaddr[s]),
			.wvalid(wvalid[s]), .wready(wready[s]), .wdata(wdata[s]), .wstrb(wstrb[s]),
			.bvalid(bvalid[s]), .bready(bready[s]), .bresp(bresp[s]),
			.arvalid(arvalid[s]), .arready(arready[s]), .araddr(araddr[s]),
			.rvalid(rvalid[s]), .rready(rready[s]), .rdata(rdata[s]), .rresp(rresp[s])
		);
	end

	response_router router0 (
		.links(links),
		.rd_owner(rd_owner),
		.mem_bvalid(mem_bvalid), .mem_bready(mem_bready), .mem_bresp(mem_bresp),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
		.mem_rdata(mem_rdata), .mem_rresp(mem_rresp),
		.fetch_rvalid(fetch_rvalid), .fetch_rready(fetch_rready),
		.fetch_rdata(fetch_rdata), .fetch_rresp(fetch_rresp),
		.wr_done(wr_done), .rd_done(rd_done)
	);

endmodule

/* bench/tb_interconnect.sv */
/*
 * Interconnect testbench
 * Random fetch and memory masters, two AXI4-Lite slave models with
 * random latency, and a reference model of the slave memories.
 */
`timescale 1ns/1ps

module tb_interconnect;
	import bus_pkg::*;

	localparam addr_t TIMER_BASE = 32'h0200_0000;
	localparam addr_t TIMER_SPAN = 32'h0001_0000;
	localparam int    NUM_TRANS  = 400;
	localparam int    MAX_CYCLES = 12000;

	logic  clk, rst_n;
	logic  mem_wvalid, mem_wready, mem_bvalid, mem_bready;
	addr_t mem_waddr, mem_araddr, fetch_araddr;
	data_t mem_wdata, mem_rdata, fetch_rdata;
	strb_t mem_wstrb;
	resp_t mem_bresp, mem_rresp, fetch_rresp;
	logic  mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	logic  fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
	logic  awvalid [NUM_SLAVES], awready [NUM_SLAVES];
	logic  wvalid [NUM_SLAVES], wready [NUM_SLAVES];
	logic  bvalid [NUM_SLAVES], bready [NUM_SLAVES];
	logic  arvalid [NUM_SLAVES], arready [NUM_SLAVES];
	logic  rvalid [NUM_SLAVES], rready [NUM_SLAVES];
	addr_t awaddr [NUM_SLAVES], araddr [NUM_SLAVES];
	data_t wdata [NUM_SLAVES], rdata [NUM_SLAVES];
	strb_t wstrb [NUM_SLAVES];
	resp_t bresp [NUM_SLAVES], rresp [NUM_SLAVES];

	// slave contents and the reference copy
	data_t slv_mem [NUM_SLAVES][16];
	data_t ref_mem [NUM_SLAVES][16];
	int    exp_wr_slave;
	addr_t exp_wr_addr;
	data_t exp_wr_data;
	strb_t exp_wr_strb;
	int    exp_ar_slave [$];
	addr_t exp_ar_addr [$];
	logic  wr_wait, mem_rd_wait, fetch_rd_wait;
	logic  mem_held, fetch_held;
	data_t mem_held_data, fetch_held_data;
	int    cycles;

	bus_interconnect #(.TIMER_BASE(TIMER_BASE), .TIMER_SPAN(TIMER_SPAN)) dut0 (.*);

	always #10 clk = !clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic check_strb(input string name, input strb_t got, input strb_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic check_resp(input string name, input resp_t got, input resp_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	function automatic int slave_of(input addr_t a);
		return (a >= TIMER_BASE && a < TIMER_BASE + TIMER_SPAN) ? SLV_TIMER : SLV_EXT;
	endfunction

	function automatic addr_t offset_of(input addr_t a);
		return (slave_of(a) == SLV_TIMER) ? a - TIMER_BASE : a;
	endfunction

	function automatic resp_t resp_of(input addr_t off);
		return off[2] ? RESP_SLVERR : RESP_OKAY;
	endfunction

	function automatic addr_t pick_addr();
		addr_t r;
		r = $urandom;
		if ($urandom % 2)
			return TIMER_BASE | (r & 32'h3c);
		return 32'h8000_0000 | (r & 32'h3c);
	endfunction

	task automatic serve_writes(input int s);
		logic  got_aw, got_w;
		addr_t a;
		data_t d;
		strb_t st;
		forever begin
			got_aw = 0;
			got_w = 0;
			while (!(got_aw && got_w)) begin
				@(negedge clk);
				awready[s] = !got_aw && ($urandom % 2);
				wready[s] = !got_w && ($urandom % 2);
				@(posedge clk);
				if (awvalid[s] && awready[s]) begin
					if (s != exp_wr_slave)
						report_failure("write address reached the wrong slave");
					check_addr("awaddr", awaddr[s], exp_wr_addr);
					a = awaddr[s];
					got_aw = 1;
				end
				if (wvalid[s] && wready[s]) begin
					if (s != exp_wr_slave)
						report_failure("write data reached the wrong slave");
					check_data("wdata", wdata[s], exp_wr_data);
					check_strb("wstrb", wstrb[s], exp_wr_strb);
					d = wdata[s];
					st = wstrb[s];
					got_w = 1;
				end
			end
			@(negedge clk);
			awready[s] = 0;
			wready[s] = 0;
			repeat ($urandom % 6) @(negedge clk);
			for (int b = 0; b < 4; b++)
				if (st[b])
					slv_mem[s][a[5:2]][8*b +: 8] = d[8*b +: 8];
			bvalid[s] = 1;
			bresp[s] = resp_of(a);
			do @(posedge clk); while (!bready[s]);
			@(negedge clk);
			bvalid[s] = 0;
		end
	endtask

	task automatic serve_reads(input int s);
		addr_t a;
		forever begin
			@(negedge clk);
			arready[s] = $urandom % 2;
			@(posedge clk);
			if (arvalid[s] && arready[s]) begin
				if (exp_ar_slave.size() == 0)
					report_failure("read address seen with no read expected");
				if (s != exp_ar_slave.pop_front())
					report_failure("read address reached the wrong slave");
				check_addr("araddr", araddr[s], exp_ar_addr.pop_front());
				a = araddr[s];
				@(negedge clk);
				arready[s] = 0;
				repeat ($urandom % 6) @(negedge clk);
				rvalid[s] = 1;
				rdata[s] = slv_mem[s][a[5:2]];
				rresp[s] = resp_of(a);
				do @(posedge clk); while (!rready[s]);
				@(negedge clk);
				rvalid[s] = 0;
			end
		end
	endtask

	task automatic expect_read(input addr_t a);
		exp_ar_slave.push_back(slave_of(a));
		exp_ar_addr.push_back(offset_of(a));
	endtask

	task automatic do_write(input addr_t a, input data_t d, input strb_t st);
		int    s;
		addr_t off;
		s = slave_of(a);
		off = offset_of(a);
		exp_wr_slave = s;
		exp_wr_addr = off;
		exp_wr_data = d;
		exp_wr_strb = st;
		for (int b = 0; b < 4; b++)
			if (st[b])
				ref_mem[s][off[5:2]][8*b +: 8] = d[8*b +: 8];
		wr_wait = 1;
		@(negedge clk);
		mem_wvalid = 1;
		mem_waddr = a;
		mem_wdata = d;
		mem_wstrb = st;
		do @(posedge clk); while (!mem_wready);
		forever begin
			@(negedge clk);
			mem_wvalid = 0;
			mem_bready = $urandom % 2;
			@(posedge clk);
			if (mem_bvalid && mem_bready)
				break;
		end
		check_resp("mem_bresp", mem_bresp, resp_of(off));
		@(negedge clk);
		wr_wait = 0;
		mem_bready = 0;
	endtask

	task automatic do_read(input logic fetch, input addr_t a);
		data_t exp_d;
		resp_t exp_r;
		exp_d = ref_mem[slave_of(a)][offset_of(a) >> 2 & 15];
		exp_r = resp_of(offset_of(a));
		@(negedge clk);
		if (fetch) begin
			fetch_rd_wait = 1;
			fetch_arvalid = 1;
			fetch_araddr = a;
			do @(posedge clk); while (!fetch_arready);
			forever begin
				@(negedge clk);
				fetch_arvalid = 0;
				fetch_rready = $urandom % 2;
				@(posedge clk);
				if (fetch_rvalid && fetch_rready)
					break;
			end
			check_data("fetch_rdata", fetch_rdata, exp_d);
			check_resp("fetch_rresp", fetch_rresp, exp_r);
			@(negedge clk);
			fetch_rd_wait = 0;
			fetch_rready = 0;
		end else begin
			mem_rd_wait = 1;
			mem_arvalid = 1;
			mem_araddr = a;
			do @(posedge clk); while (!mem_arready);
			forever begin
				@(negedge clk);
				mem_arvalid = 0;
				mem_rready = $urandom % 2;
				@(posedge clk);
				if (mem_rvalid && mem_rready)
					break;
			end
			check_data("mem_rdata", mem_rdata, exp_d);
			check_resp("mem_rresp", mem_rresp, exp_r);
			@(negedge clk);
			mem_rd_wait = 0;
			mem_rready = 0;
		end
	endtask

	// responses go only to a waiting master and hold until taken
	always @(posedge clk) begin
		if (rst_n) begin
			if (mem_bvalid && !wr_wait)
				report_failure("write response with no write outstanding");
			if (mem_rvalid && !mem_rd_wait)
				report_failure("memory master got a read response it did not ask for");
			if (fetch_rvalid && !fetch_rd_wait)
				report_failure("fetch master got a read response it did not ask for");
			if (mem_held) begin
				if (!mem_rvalid)
					report_failure("mem_rvalid dropped before the response was taken");
				check_data("mem_rdata", mem_rdata, mem_held_data);
			end
			if (fetch_held) begin
				if (!fetch_rvalid)
					report_failure("fetch_rvalid dropped before the response was taken");
				check_data("fetch_rdata", fetch_rdata, fetch_held_data);
			end
			if (((mem_rvalid && !mem_rready) || (fetch_rvalid && !fetch_rready)) &&
					(rready[0] || rready[1]))
				report_failure("slave rready high while the master holds rready low");
			if (mem_bvalid && !mem_bready && (bready[0] || bready[1]))
				report_failure("slave bready high while the master holds bready low");
			mem_held = mem_rvalid && !mem_rready;
			mem_held_data = mem_rdata;
			fetch_held = fetch_rvalid && !fetch_rready;
			fetch_held_data = fetch_rdata;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			report_failure("timeout, the transactions did not finish in time");
	end

	initial begin
		addr_t wa, ra;
		int    kind;
		void'($urandom(32'h9423_f2a7));
		clk = 0;
		rst_n = 0;
		cycles = 0;
		{mem_wvalid, mem_bready, mem_arvalid, mem_rready} = '0;
		{fetch_arvalid, fetch_rready} = '0;
		{mem_waddr, mem_wdata, mem_wstrb, mem_araddr, fetch_araddr} = '0;
		{wr_wait, mem_rd_wait, fetch_rd_wait, mem_held, fetch_held} = '0;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			{awready[s], wready[s], bvalid[s], arready[s], rvalid[s]} = '0;
			bresp[s] = RESP_OKAY;
			rresp[s] = RESP_OKAY;
			rdata[s] = '0;
			for (int i = 0; i < 16; i++) begin
				slv_mem[s][i] = 32'h5a00_0000 ^ (s << 16) ^ (i * 32'h0101);
				ref_mem[s][i] = slv_mem[s][i];
			end
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1;
		@(posedge clk);
		for (int s = 0; s < NUM_SLAVES; s++)
			if (awvalid[s] || wvalid[s] || arvalid[s])
				report_failure("slave valid high after reset");
		if (mem_bvalid || mem_rvalid || fetch_rvalid)
			report_failure("master response valid high after reset");
		if (!mem_wready || !mem_arready || !fetch_arready)
			report_failure("master request ready low after reset");
		fork
			serve_writes(0);
			serve_writes(1);
			serve_reads(0);
			serve_reads(1);
		join_none
		for (int t = 0; t < NUM_TRANS; t++) begin
			kind = $urandom % 5;
			wa = pick_addr();
			ra = pick_addr();
			case (kind)
				0: do_write(wa, $urandom, $urandom);
				1: begin
					expect_read(ra);
					do_read(0, ra);
				end
				2: begin
					expect_read(ra);
					do_read(1, ra);
				end
				3: begin
					// memory master must win the same-cycle request
					expect_read(ra);
					expect_read(wa);
					fork
						do_read(0, ra);
						do_read(1, wa);
					join
				end
				default: begin
					// the read never hits the word being written
					if ($urandom % 2)
						ra = wa ^ 32'h20;
					else if (ra[5:2] == wa[5:2])
						ra = ra ^ 32'h20;
					expect_read(ra);
					fork
						do_write(wa, $urandom, $urandom);
						do_read($urandom % 2, ra);
					join
				end
			endcase
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* tb.f */
hdl/bus_pkg.sv
hdl/slave_link_if.sv
hdl/request_arbiter.sv
hdl/slave_port.sv
hdl/response_router.sv
hdl/bus_interconnect.sv
bench/tb_interconnect.sv
